// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_pipe
RTL_TOP   ?= rv_pipe_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+verification
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_hazard_ctrl.sv
source/rv_execute.sv
source/rv_mem_wb.sv
source/rv_pipe_top.sv
verification/tb_rv_pipe.sv

// ==== source/rv_decode.sv ====
`timescale 1ns/10ps

module rv_decode (
    input  logic              clk_100mhz_i,
    input  logic              arst_n_i,
    input  logic              freeze_i,
    input  logic              flush_i,
    input  rv_pkg::inst_t     inst_i,
    input  rv_pkg::addr_t     pc_i,
    input  logic              wb_ena_i,
    input  rv_pkg::reg_addr_t wb_rd_i,
    input  rv_pkg::word_t     wb_data_i,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::reg_addr_t ex_rs1_o,
    output rv_pkg::reg_addr_t ex_rs2_o,
    output rv_pkg::reg_addr_t ex_rd_o,
    output rv_pkg::word_t     ex_op_a_o,
    output rv_pkg::word_t     ex_op_b_o,
    output rv_pkg::word_t     ex_imm_o,
    output rv_pkg::addr_t     ex_pc_o,
    output logic              ex_reg_w_o,
    output logic              ex_load_o,
    output logic              ex_store_o,
    output logic              ex_branch_o,
    output logic              ex_sub_o,
    output logic              ex_use_imm_o
);
    import rv_pkg::*;

    word_t      regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_add, is_sub, is_addi, is_lw, is_sw, is_beq;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign is_add  = opcode == OP_RTYPE && funct3 == F3_ADD && funct7 == 7'b0;
    assign is_sub  = opcode == OP_RTYPE && funct3 == F3_ADD && funct7 == F7_SUB;
    assign is_addi = opcode == OP_ITYPE && funct3 == F3_ADD;
    assign is_lw   = opcode == OP_LOAD && funct3 == F3_WORD;
    assign is_sw   = opcode == OP_STORE && funct3 == F3_WORD;
    assign is_beq  = opcode == OP_BRANCH && funct3 == F3_BEQ;

    // unused source fields read as x0, so they never stall or forward
    assign rs1_o = (is_add || is_sub || is_addi || is_lw || is_sw || is_beq) ?
                   inst_i[19:15] : '0;
    assign rs2_o = (is_add || is_sub || is_sw || is_beq) ? inst_i[24:20] : '0;

    always_comb begin
        if (is_sw) begin
            imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
        end else if (is_beq) begin
            imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
        end else begin
            imm = {{20{inst_i[31]}}, inst_i[31:20]};    // addi, lw
        end
    end

    // write-through covers the write landing in this same cycle
    assign rs1_data = (wb_ena_i && wb_rd_i != '0 && wb_rd_i == rs1_o) ? wb_data_i : regs[rs1_o];
    assign rs2_data = (wb_ena_i && wb_rd_i != '0 && wb_rd_i == rs2_o) ? wb_data_i : regs[rs2_o];

    always_ff @(posedge clk_100mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_ena_i && !freeze_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;    // x0 never written
        end
    end

    // decode/execute register, bubble on flush
    always_ff @(posedge clk_100mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_rs1_o    <= '0;
            ex_rs2_o    <= '0;
            ex_rd_o     <= '0;
            ex_reg_w_o  <= 1'b0;
            ex_load_o   <= 1'b0;
            ex_store_o  <= 1'b0;
            ex_branch_o <= 1'b0;
        end else if (!freeze_i) begin
            ex_rs1_o    <= flush_i ? '0 : rs1_o;
            ex_rs2_o    <= flush_i ? '0 : rs2_o;
            ex_rd_o     <= flush_i ? '0 : inst_i[11:7];
            ex_reg_w_o  <= !flush_i && (is_add || is_sub || is_addi || is_lw);
            ex_load_o   <= !flush_i && is_lw;
            ex_store_o  <= !flush_i && is_sw;
            ex_branch_o <= !flush_i && is_beq;
        end
    end

    always_ff @(posedge clk_100mhz_i) begin
        if (!freeze_i) begin
            ex_op_a_o    <= rs1_data;
            ex_op_b_o    <= rs2_data;
            ex_imm_o     <= imm;
            ex_pc_o      <= pc_i;
            ex_sub_o     <= is_sub;
            ex_use_imm_o <= is_addi || is_lw || is_sw;
        end
    end

    // relies on the write port never touching entry 0
    x0_zero_a: assert property (@(posedge clk_100mhz_i) disable iff (!arst_n_i)
        rs1_o == '0 |-> rs1_data == '0);

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/10ps

module rv_execute (
    input  logic              clk_100mhz_i,
    input  logic              arst_n_i,
    input  logic              freeze_i,
    input  rv_pkg::reg_addr_t ex_rs2_i,
    input  rv_pkg::reg_addr_t ex_rd_i,
    input  rv_pkg::word_t     ex_op_a_i,
    input  rv_pkg::word_t     ex_op_b_i,
    input  rv_pkg::word_t     ex_imm_i,
    input  rv_pkg::addr_t     ex_pc_i,
    input  logic              ex_reg_w_i,
    input  logic              ex_load_i,
    input  logic              ex_store_i,
    input  logic              ex_branch_i,
    input  logic              ex_sub_i,
    input  logic              ex_use_imm_i,
    input  rv_pkg::fwd_sel_t  fwd_a_i,
    input  rv_pkg::fwd_sel_t  fwd_b_i,
    input  rv_pkg::word_t     mem_fwd_data_i,
    input  rv_pkg::word_t     wb_fwd_data_i,
    output logic              branch_taken_o,
    output rv_pkg::addr_t     branch_target_o,
    output rv_pkg::word_t     mem_result_o,
    output rv_pkg::word_t     mem_store_data_o,
    output rv_pkg::reg_addr_t mem_rd_o,
    output rv_pkg::reg_addr_t mem_rs2_o,
    output logic              mem_reg_w_o,
    output logic              mem_load_o,
    output logic              mem_store_o
);
    import rv_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t result;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t exm, word_t mwb);
        case (sel)
            FWD_EXM: return exm;
            FWD_MWB: return mwb;
            default: return reg_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a_i, ex_op_a_i, mem_fwd_data_i, wb_fwd_data_i);
    assign op_b = fwd_mux(fwd_b_i, ex_op_b_i, mem_fwd_data_i, wb_fwd_data_i);

    // addi, lw and sw all add the immediate to rs1
    assign alu_b  = ex_use_imm_i ? ex_imm_i : op_b;
    assign result = ex_sub_i ? op_a - alu_b : op_a + alu_b;

    assign branch_taken_o  = ex_branch_i && (op_a == op_b);    // beq
    assign branch_target_o = ex_pc_i + ex_imm_i;

    // execute/memory register
    always_ff @(posedge clk_100mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_rd_o    <= '0;
            mem_rs2_o   <= '0;
            mem_reg_w_o <= 1'b0;
            mem_load_o  <= 1'b0;
            mem_store_o <= 1'b0;
        end else if (!freeze_i) begin
            mem_rd_o    <= ex_rd_i;
            mem_rs2_o   <= ex_rs2_i;
            mem_reg_w_o <= ex_reg_w_i;
            mem_load_o  <= ex_load_i;
            mem_store_o <= ex_store_i;
        end
    end

    always_ff @(posedge clk_100mhz_i) begin
        if (!freeze_i) begin
            mem_result_o     <= result;
            mem_store_data_o <= op_b;    // forwarded rs2
        end
    end

    // a taken beq leaves a bubble behind it in execute
    branch_flush_a: assert property (@(posedge clk_100mhz_i) disable iff (!arst_n_i)
        branch_taken_o && !freeze_i |-> ex_branch_i
            ##1 !(ex_branch_i || ex_reg_w_i || ex_load_i || ex_store_i));

endmodule

// ==== source/rv_fetch.sv ====
`timescale 1ns/10ps

module rv_fetch (
    input  logic          clk_100mhz_i,
    input  logic          arst_n_i,
    input  logic          freeze_i,
    input  logic          stall_i,
    input  logic          flush_i,
    input  logic          branch_taken_i,
    input  rv_pkg::addr_t branch_target_i,
    input  rv_pkg::inst_t rom_data_i,
    output rv_pkg::addr_t pc_o,
    output rv_pkg::inst_t if_inst_o,
    output rv_pkg::addr_t if_pc_o
);
    import rv_pkg::*;

    addr_t pc_next;

    // redirect beats the load-use stall
    always_comb begin
        if (branch_taken_i) begin
            pc_next = branch_target_i;
        end else if (stall_i) begin
            pc_next = pc_o;
        end else begin
            pc_next = pc_o + 32'd4;
        end
    end

    always_ff @(posedge clk_100mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= RESET_PC;
        end else if (!freeze_i) begin
            pc_o <= pc_next;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk_100mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_inst_o <= NOP_INST;
            if_pc_o   <= RESET_PC;
        end else if (!freeze_i) begin
            if (flush_i) begin
                if_inst_o <= NOP_INST;    // squash wrong-path fetch
            end else if (!stall_i) begin
                if_inst_o <= rom_data_i;
                if_pc_o   <= pc_o;
            end
        end
    end

    // branch targets come from execute, so this covers the whole redirect path
    pc_aligned_a: assert property (@(posedge clk_100mhz_i) disable iff (!arst_n_i)
        pc_o[1:0] == 2'b00);

endmodule

// ==== source/rv_hazard_ctrl.sv ====
`timescale 1ns/10ps

module rv_hazard_ctrl (
    input  logic              hold_i,
    input  rv_pkg::reg_addr_t id_rs1_i,
    input  rv_pkg::reg_addr_t id_rs2_i,
    input  rv_pkg::reg_addr_t ex_rs1_i,
    input  rv_pkg::reg_addr_t ex_rs2_i,
    input  rv_pkg::reg_addr_t ex_rd_i,
    input  logic              ex_load_i,
    input  rv_pkg::reg_addr_t mem_rd_i,
    input  logic              mem_reg_w_i,
    input  logic              mem_store_i,
    input  rv_pkg::reg_addr_t mem_rs2_i,
    input  rv_pkg::reg_addr_t wb_rd_i,
    input  logic              wb_ena_i,
    input  logic              branch_taken_i,
    output logic              freeze_o,
    output logic              stall_front_o,
    output logic              flush_if_id_o,
    output logic              flush_id_ex_o,
    output rv_pkg::fwd_sel_t  fwd_a_o,
    output rv_pkg::fwd_sel_t  fwd_b_o,
    output logic              fwd_store_o
);
    import rv_pkg::*;

    logic load_use;

    // newest producer wins, x0 never forwarded
    function automatic fwd_sel_t fwd_pick(reg_addr_t rs, reg_addr_t m_rd, logic m_w,
                                          reg_addr_t w_rd, logic w_ena);
        if (m_w && m_rd != '0 && m_rd == rs) begin
            return FWD_EXM;
        end else if (w_ena && w_rd != '0 && w_rd == rs) begin
            return FWD_MWB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a_o = fwd_pick(ex_rs1_i, mem_rd_i, mem_reg_w_i, wb_rd_i, wb_ena_i);
    assign fwd_b_o = fwd_pick(ex_rs2_i, mem_rd_i, mem_reg_w_i, wb_rd_i, wb_ena_i);

    // store in memory, its data written by the instruction now in writeback
    assign fwd_store_o = mem_store_i && wb_ena_i && wb_rd_i != '0 && wb_rd_i == mem_rs2_i;

    assign load_use = ex_load_i && ex_rd_i != '0 && (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

    assign freeze_o      = hold_i;
    assign stall_front_o = load_use;
    assign flush_if_id_o = branch_taken_i;
    assign flush_id_ex_o = branch_taken_i || load_use;    // bubble into execute

    // a load and a taken branch can never share the execute slot
    always_comb begin
        if (!hold_i) begin
            assert (!(stall_front_o && flush_if_id_o))
                else $error("load-use stall together with branch flush");
        end
    end

endmodule

// ==== source/rv_mem_wb.sv ====
`timescale 1ns/10ps

module rv_mem_wb (
    input  logic              clk_100mhz_i,
    input  logic              arst_n_i,
    input  logic              freeze_i,
    input  logic              fwd_store_i,
    input  rv_pkg::word_t     mem_result_i,
    input  rv_pkg::word_t     mem_store_data_i,
    input  rv_pkg::reg_addr_t mem_rd_i,
    input  logic              mem_reg_w_i,
    input  logic              mem_load_i,
    input  logic              mem_store_i,
    input  rv_pkg::word_t     ram_r_data_i,
    output logic              ram_r_ena_o,
    output rv_pkg::addr_t     ram_r_addr_o,
    output logic              ram_w_ena_o,
    output rv_pkg::addr_t     ram_w_addr_o,
    output rv_pkg::word_t     ram_w_data_o,
    output logic              wb_ena_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output rv_pkg::word_t     wb_data_o
);
    import rv_pkg::*;

    word_t store_data;

    assign store_data = fwd_store_i ? wb_data_o : mem_store_data_i;

    // read and write both issue from the memory stage
    assign ram_r_ena_o  = mem_load_i;
    assign ram_r_addr_o = mem_result_i;
    assign ram_w_ena_o  = mem_store_i && !freeze_i;    // one strobe per store
    assign ram_w_addr_o = mem_result_i;
    assign ram_w_data_o = store_data;

    always_ff @(posedge clk_100mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ena_o <= 1'b0;
            wb_rd_o  <= '0;
        end else if (!freeze_i) begin
            wb_ena_o <= mem_reg_w_i;
            wb_rd_o  <= mem_rd_i;
        end
    end

    always_ff @(posedge clk_100mhz_i) begin
        if (!freeze_i) begin
            wb_data_o <= mem_load_i ? ram_r_data_i : mem_result_i;
        end
    end

endmodule

// ==== source/rv_pipe_top.sv ====
`timescale 1ns/10ps

module rv_pipe_top (
    input  logic          clk_100mhz_i,
    input  logic          arst_n_i,
    input  logic          hold_i,
    input  rv_pkg::inst_t rom_r_data_i,
    input  rv_pkg::word_t ram_r_data_i,
    output rv_pkg::addr_t rom_r_addr_o,
    output logic          ram_r_ena_o,
    output rv_pkg::addr_t ram_r_addr_o,
    output logic          ram_w_ena_o,
    output rv_pkg::addr_t ram_w_addr_o,
    output rv_pkg::word_t ram_w_data_o
);
    import rv_pkg::*;

    // controller
    logic      freeze, stall_front, flush_if_id, flush_id_ex, fwd_store;
    fwd_sel_t  fwd_a, fwd_b;

    inst_t     if_inst;
    addr_t     if_pc;
    reg_addr_t id_rs1, id_rs2;

    // decode/execute
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    word_t     ex_op_a, ex_op_b, ex_imm;
    addr_t     ex_pc;
    logic      ex_reg_w, ex_load, ex_store, ex_branch, ex_sub, ex_use_imm;
    logic      branch_taken;
    addr_t     branch_target;

    // execute/memory
    word_t     mem_result, mem_store_data;
    reg_addr_t mem_rd, mem_rs2;
    logic      mem_reg_w, mem_load, mem_store;

    logic      wb_ena;
    reg_addr_t wb_rd;
    word_t     wb_data;

    rv_fetch u_fetch (
        .clk_100mhz_i(clk_100mhz_i), .arst_n_i(arst_n_i),
        .freeze_i(freeze), .stall_i(stall_front), .flush_i(flush_if_id),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .rom_data_i(rom_r_data_i), .pc_o(rom_r_addr_o),
        .if_inst_o(if_inst), .if_pc_o(if_pc)
    );

    rv_decode u_decode (
        .clk_100mhz_i(clk_100mhz_i), .arst_n_i(arst_n_i),
        .freeze_i(freeze), .flush_i(flush_id_ex), .inst_i(if_inst), .pc_i(if_pc),
        .wb_ena_i(wb_ena), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .rs1_o(id_rs1), .rs2_o(id_rs2),
        .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2), .ex_rd_o(ex_rd),
        .ex_op_a_o(ex_op_a), .ex_op_b_o(ex_op_b), .ex_imm_o(ex_imm), .ex_pc_o(ex_pc),
        .ex_reg_w_o(ex_reg_w), .ex_load_o(ex_load), .ex_store_o(ex_store),
        .ex_branch_o(ex_branch), .ex_sub_o(ex_sub), .ex_use_imm_o(ex_use_imm)
    );

    rv_hazard_ctrl u_hazard_ctrl (
        .hold_i(hold_i), .id_rs1_i(id_rs1), .id_rs2_i(id_rs2),
        .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd), .ex_load_i(ex_load),
        .mem_rd_i(mem_rd), .mem_reg_w_i(mem_reg_w),
        .mem_store_i(mem_store), .mem_rs2_i(mem_rs2),
        .wb_rd_i(wb_rd), .wb_ena_i(wb_ena), .branch_taken_i(branch_taken),
        .freeze_o(freeze), .stall_front_o(stall_front),
        .flush_if_id_o(flush_if_id), .flush_id_ex_o(flush_id_ex),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .fwd_store_o(fwd_store)
    );

    rv_execute u_execute (
        .clk_100mhz_i(clk_100mhz_i), .arst_n_i(arst_n_i), .freeze_i(freeze),
        .ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd),
        .ex_op_a_i(ex_op_a), .ex_op_b_i(ex_op_b), .ex_imm_i(ex_imm), .ex_pc_i(ex_pc),
        .ex_reg_w_i(ex_reg_w), .ex_load_i(ex_load), .ex_store_i(ex_store),
        .ex_branch_i(ex_branch), .ex_sub_i(ex_sub), .ex_use_imm_i(ex_use_imm),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .mem_fwd_data_i(mem_result), .wb_fwd_data_i(wb_data),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .mem_result_o(mem_result), .mem_store_data_o(mem_store_data),
        .mem_rd_o(mem_rd), .mem_rs2_o(mem_rs2),
        .mem_reg_w_o(mem_reg_w), .mem_load_o(mem_load), .mem_store_o(mem_store)
    );

    rv_mem_wb u_mem_wb (
        .clk_100mhz_i(clk_100mhz_i), .arst_n_i(arst_n_i),
        .freeze_i(freeze), .fwd_store_i(fwd_store),
        .mem_result_i(mem_result), .mem_store_data_i(mem_store_data),
        .mem_rd_i(mem_rd), .mem_reg_w_i(mem_reg_w),
        .mem_load_i(mem_load), .mem_store_i(mem_store),
        .ram_r_data_i(ram_r_data_i), .ram_r_ena_o(ram_r_ena_o), .ram_r_addr_o(ram_r_addr_o),
        .ram_w_ena_o(ram_w_ena_o), .ram_w_addr_o(ram_w_addr_o), .ram_w_data_o(ram_w_data_o),
        .wb_ena_o(wb_ena), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;    // register and ram data
    typedef logic [XLEN-1:0] addr_t;    // byte address, rom ram and pc
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [1:0]      fwd_sel_t;

    // alu operand source
    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_EXM = 2'd1;    // execute/memory alu result
    localparam fwd_sel_t FWD_MWB = 2'd2;    // memory/writeback data

    // opcodes of the supported subset
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_WORD = 3'b010;    // lw / sw

    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam inst_t NOP_INST = 32'h0000_0013;    // addi x0, x0, 0
    localparam addr_t RESET_PC = '0;

endpackage

// ==== verification/tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

localparam logic [31:0] LOOP_INST = 32'h0000_0063;    // beq x0, x0, 0
localparam logic [31:0] NOP_WORD  = 32'h0000_0013;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

// initial ram word, mixes every address bit
function automatic logic [31:0] ram_fill(logic [5:0] idx);
    return ({26'd0, idx} * 32'h0101_0107) ^ 32'h5a00_0000;
endfunction

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ LFSR_TAPS;
        end
        v = {v[30:0], b};
    end
    return v;
endfunction

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                      logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_beq(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

// sequential interpreter of the rom, fills the expected store list
function automatic void run_model();
    logic [31:0] x [32];
    logic [31:0] mem [64];
    logic [31:0] pc, inst, a, b, ea, imm_i, imm_s, imm_b;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int          steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 64; i++) mem[i] = ram_fill(6'(i));
    exp_addr.delete();
    exp_data.delete();
    pc    = '0;
    steps = 0;
    while (steps < 4000) begin
        inst = rom[pc[9:2]];
        if (inst == LOOP_INST) break;
        a     = x[inst[19:15]];
        b     = x[inst[24:20]];
        f3    = inst[14:12];
        f7    = inst[31:25];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        ea    = a + ((inst[6:0] == 7'b0100011) ? imm_s : imm_i);
        pc    = pc + 32'd4;
        case (inst[6:0])
            7'b0110011: begin
                if (f3 == 3'b000 && f7 == 7'b0000000) x[inst[11:7]] = a + b;
                else if (f3 == 3'b000 && f7 == 7'b0100000) x[inst[11:7]] = a - b;
            end
            7'b0010011: if (f3 == 3'b000) x[inst[11:7]] = a + imm_i;
            7'b0000011: if (f3 == 3'b010) x[inst[11:7]] = mem[ea[7:2]];
            7'b0100011: begin
                if (f3 == 3'b010) begin
                    mem[ea[7:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
            end
            7'b1100011: if (f3 == 3'b000 && a == b) pc = pc - 32'd4 + imm_b;
            default: ;    // anything else is a no-op
        endcase
        x[0] = '0;
        steps++;
    end
endfunction

`endif

// ==== verification/tb_rv_pipe.sv ====
`timescale 1ns/10ps

module tb_rv_pipe;

    localparam int NUM_TESTS = 10;
    localparam int MAX_LEN   = 80;    // words per program
    localparam int CLK_NS    = 4;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        hold;
    logic [31:0] rom_addr, rom_data, ram_r_data, ram_r_addr, ram_w_addr, ram_w_data;
    logic        ram_r_ena, ram_w_ena;

    logic [31:0] rom [256];
    logic [31:0] ram [64];
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] obs_addr [$];
    logic [31:0] lfsr_q = 32'h7a6a;
    logic [31:0] pc_prev = '0;
    logic        hold_prev = 1'b0;
    logic        hold_en = 1'b0;
    logic        checking = 1'b0;
    int          errors = 0;
    int          extra = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    `include "tb_rv_model.svh"

    rv_pipe_top UUT (
        .clk_100mhz_i(clk), .arst_n_i(arst_n), .hold_i(hold),
        .rom_r_data_i(rom_data), .ram_r_data_i(ram_r_data), .rom_r_addr_o(rom_addr),
        .ram_r_ena_o(ram_r_ena), .ram_r_addr_o(ram_r_addr), .ram_w_ena_o(ram_w_ena),
        .ram_w_addr_o(ram_w_addr), .ram_w_data_o(ram_w_data)
    );

    always #2 clk = ~clk;

    assign rom_data   = rom[rom_addr[9:2]];
    assign ram_r_data = ram[ram_r_addr[7:2]];

    // ram model plus store compare and hold checks
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) ram[i] <= ram_fill(6'(i));
        end else if (ram_w_ena) begin
            ram[ram_w_addr[7:2]] <= ram_w_data;
            if (checking) begin
                if (obs_addr.size() >= exp_addr.size()) begin
                    extra++;
                end else if (ram_w_addr !== exp_addr[obs_addr.size()] ||
                             ram_w_data !== exp_data[obs_addr.size()]) begin
                    $display("FAIL %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                             obs_addr.size(), ram_w_data, ram_w_addr,
                             exp_data[obs_addr.size()], exp_addr[obs_addr.size()]);
                    errors++;
                end
                obs_addr.push_back(ram_w_addr);
            end
            if (hold) begin
                $display("FAIL %0t: ram write while hold is high", $time);
                errors++;
            end
        end
        if (hold_prev && rom_addr !== pc_prev) begin
            $display("FAIL %0t: pc moved from %h to %h under hold", $time, pc_prev, rom_addr);
            errors++;
        end
        hold_prev = hold;
        pc_prev   = rom_addr;
    end

    // random hold pulses
    always @(posedge clk) begin
        #1;
        hold <= hold_en ? (rand_bits(2) == 32'd0) : 1'b0;
    end

    task automatic emit(input logic [31:0] inst);
        prog.push_back(inst);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n  = 1'b0;
        hold_en = 1'b0;
        obs_addr.delete();
        extra = 0;
        for (int i = 0; i < 256; i++) rom[i] = (i < prog.size()) ? prog[i] : NOP_WORD;
        repeat (8) begin
            @(posedge clk);
            #1;
            if (ram_w_ena !== 1'b0 || ram_r_ena !== 1'b0 || rom_addr !== 32'd0) begin
                $display("FAIL %0t: ram strobe or pc not idle in reset", $time);
                errors++;
            end
        end
        arst_n = 1'b1;
        #0.5;
        if (rom_addr !== 32'd0 || ram_w_ena !== 1'b0 || ram_r_ena !== 1'b0) begin
            $display("FAIL %0t: pc %h or ram strobes wrong after reset", $time, rom_addr);
            errors++;
        end
    endtask

    task automatic run_test(input string name, input bit use_hold);
        int          err0;
        int          waited;
        logic [31:0] loop_pc;
        err0    = errors;
        loop_pc = 32'(4 * (prog.size() - 1));
        apply_reset();
        run_model();
        checking = 1'b1;
        hold_en  = use_hold;
        waited   = 0;
        @(negedge clk);
        while (rom_addr !== loop_pc && waited < MAX_LEN * 6) begin
            @(negedge clk);
            waited++;
        end
        hold_en = 1'b0;
        repeat (14) @(negedge clk);    // drain stores ahead of the loop
        checking = 1'b0;
        if (waited >= MAX_LEN * 6) begin
            $display("%s: the program never reached its final loop", name);
            errors++;
        end
        if (obs_addr.size() < exp_addr.size()) begin
            $display("%s: %0d expected stores never reached the ram", name,
                     exp_addr.size() - obs_addr.size());
            errors++;
        end
        if (extra != 0) begin
            $display("%s: %0d stores appeared that the model never made", name, extra);
            errors++;
        end
        tests_run++;
        if (errors != err0) tests_failed++;
        $display("test %s done, %0d stores, %0d errors", name, obs_addr.size(), errors - err0);
    endtask

    task automatic build_random();
        logic [31:0] k;
        logic [4:0]  rd, rs1, rs2;
        prog.delete();
        for (int r = 1; r < 8; r++) begin
            emit(enc_i(7'b0010011, 3'b000, 5'(r), 5'd0, 12'(rand_bits(12))));
        end
        for (int n = 0; n < 24; n++) begin
            k   = rand_bits(3);
            rd  = 5'(rand_bits(3));
            rs1 = 5'(rand_bits(3));
            rs2 = 5'(rand_bits(3));
            case (k[2:0])
                3'd0, 3'd6: emit(enc_r(7'b0000000, rs2, rs1, rd));
                3'd1: emit(enc_r(7'b0100000, rs2, rs1, rd));
                3'd2, 3'd7: emit(enc_i(7'b0010011, 3'b000, rd, rs1, 12'(rand_bits(12))));
                3'd3: emit(enc_i(7'b0000011, 3'b010, rd, 5'd0, {4'd0, 6'(rand_bits(6)), 2'b00}));
                3'd4: emit(enc_sw(rs2, 5'd0, {4'd0, 6'(rand_bits(6)), 2'b00}));
                default: emit(enc_beq(rs1, rs2, 13'd8));    // skips one
            endcase
        end
        for (int r = 1; r < 32; r++) emit(enc_sw(5'(r), 5'd0, 12'(128 + 4 * r)));
        emit(LOOP_INST);
    endtask

    initial begin
        #(NUM_TESTS * MAX_LEN * 8 * CLK_NS);
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        hold   = 1'b0;
        prog.delete();
        emit(LOOP_INST);
        apply_reset();
        tests_run++;
        if (errors != 0) tests_failed++;
        $display("test reset done, %0d errors", errors);

        prog.delete();
        emit(enc_i(7'b0010011, 3'b000, 5'd1, 5'd0, 12'd5));
        emit(enc_i(7'b0010011, 3'b000, 5'd2, 5'd1, 12'd7));
        emit(enc_r(7'b0000000, 5'd2, 5'd1, 5'd3));
        emit(enc_r(7'b0100000, 5'd1, 5'd3, 5'd4));
        emit(enc_r(7'b0000000, 5'd4, 5'd4, 5'd5));
        emit(enc_i(7'b0010011, 3'b000, 5'd6, 5'd5, -12'sd3));
        for (int r = 1; r < 7; r++) emit(enc_sw(5'(r), 5'd0, 12'(4 * r)));
        emit(LOOP_INST);
        run_test("forwarding", 1'b0);

        prog.delete();
        emit(enc_i(7'b0000011, 3'b010, 5'd1, 5'd0, 12'd8));
        emit(enc_r(7'b0000000, 5'd1, 5'd1, 5'd2));
        emit(enc_sw(5'd1, 5'd0, 12'd16));
        emit(enc_i(7'b0000011, 3'b010, 5'd3, 5'd0, 12'd12));
        emit(enc_sw(5'd3, 5'd0, 12'd20));
        emit(enc_i(7'b0010011, 3'b000, 5'd4, 5'd3, 12'd1));
        emit(enc_i(7'b0000011, 3'b010, 5'd5, 5'd0, 12'd24));
        emit(NOP_WORD);
        emit(enc_sw(5'd5, 5'd0, 12'd28));
        emit(enc_sw(5'd2, 5'd0, 12'd32));
        emit(enc_sw(5'd4, 5'd0, 12'd36));
        emit(LOOP_INST);
        run_test("load_use", 1'b0);

        prog.delete();
        emit(enc_i(7'b0010011, 3'b000, 5'd1, 5'd0, 12'd3));
        emit(enc_i(7'b0010011, 3'b000, 5'd2, 5'd0, 12'd3));
        emit(enc_beq(5'd1, 5'd2, 13'd12));    // taken
        emit(enc_sw(5'd1, 5'd0, 12'd0));
        emit(enc_sw(5'd2, 5'd0, 12'd4));
        emit(enc_sw(5'd1, 5'd0, 12'd8));
        emit(enc_beq(5'd1, 5'd0, 13'd12));    // not taken
        emit(enc_sw(5'd1, 5'd0, 12'd12));
        emit(enc_sw(5'd2, 5'd0, 12'd16));
        emit(enc_sw(5'd1, 5'd0, 12'd20));
        emit(LOOP_INST);
        run_test("branch", 1'b0);

        build_random();
        run_test("hold", 1'b1);
        for (int t = 0; t < 5; t++) begin
            build_random();
            run_test($sformatf("random%0d", t), 1'b0);
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
